/* src/fpu_fmt_pkg.sv */
package fpu_fmt_pkg;

  // --------------------------------------------------------------------------
  // binary16 encoding
  // --------------------------------------------------------------------------
  localparam int EXP_BITS = 5;
  localparam int MAN_BITS = 10;
  localparam int FP_WIDTH = 1 + EXP_BITS + MAN_BITS;
  localparam int BIAS     = 2 ** (EXP_BITS - 1) - 1;

  // Derived FMA datapath widths
  localparam int PRECISION_BITS  = MAN_BITS + 1;           // p, with implicit bit
  localparam int SUM_WIDTH       = 3 * PRECISION_BITS + 4; // Product, addend, guard and round
  localparam int LOWER_SUM_WIDTH = 2 * PRECISION_BITS + 3; // Span searched for leading zeros
  localparam int LZC_WIDTH       = $clog2(LOWER_SUM_WIDTH);
  localparam int EXP_WIDTH       = (EXP_BITS + 2 > LZC_WIDTH) ? EXP_BITS + 2 : LZC_WIDTH;
  localparam int SHAMT_WIDTH     = $clog2(3 * PRECISION_BITS + 3);

  localparam logic [FP_WIDTH-1:0] QNAN = 16'h7E00; // Canonical quiet NaN

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

endpackage

/* src/fpu_op_pkg.sv */
package fpu_op_pkg;

  // --------------------------------------------------------------------------
  // Operations, rounding modes and exception flags
  // --------------------------------------------------------------------------
  // op_mod flips the addend sign: FMSUB, FNMADD and SUB
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB, // Negated product
    ADD,    // a forced to +1.0
    MUL     // c forced to -0
  } operation_e;

  typedef enum logic [2:0] {
    RNE = 3'd0, // Nearest, ties to even
    RTZ = 3'd1,
    RDN = 3'd2, // Towards -inf
    RUP = 3'd3, // Towards +inf
    RMM = 3'd4  // Nearest, ties away from zero
  } roundmode_e;

  typedef struct packed {
    logic NV; // Invalid operation
    logic DZ; // Divide by zero, never raised by the FMA
    logic OF;
    logic UF;
    logic NX;
  } status_t;

endpackage

/* src/fma_ifs.sv */
`timescale 1ns/1ps

// Stage 0 operands and bypass info, combinational
interface fma_operand_if import fpu_fmt_pkg::*; import fpu_op_pkg::*; ();
  fp_t        a, b, c;                // Operands after the operation table
  fp_info_t   info_a, info_b, info_c;
  logic       effective_sub;          // Product and addend signs differ
  logic       tentative_sign;         // Sign of the product
  logic       result_is_special;
  fp_t        special_result;
  status_t    special_status;
  roundmode_e rnd_mode;

  modport prep (output a, b, c, info_a, info_b, info_c, effective_sub, tentative_sign,
                output result_is_special, special_result, special_status, rnd_mode);
  modport align (input a, b, c, info_a, info_b, info_c, effective_sub, tentative_sign,
                 input result_is_special, special_result, special_status, rnd_mode);
endinterface

// Stage 1 register contents
interface fma_stage_if import fpu_fmt_pkg::*; import fpu_op_pkg::*; ();
  logic        [SUM_WIDTH-1:0]   sum;
  logic signed [EXP_WIDTH-1:0]   exponent_product, exponent_difference, tentative_exponent;
  logic        [SHAMT_WIDTH-1:0] addend_shamt;
  logic                          sticky_before_add, final_sign, effective_sub;
  roundmode_e                    rnd_mode;
  logic                          result_is_special;
  fp_t                           special_result;
  status_t                       special_status;

  modport producer (output sum, exponent_product, exponent_difference, tentative_exponent,
                    output addend_shamt, sticky_before_add, final_sign, effective_sub,
                    output rnd_mode, result_is_special, special_result, special_status);
  modport consumer (input sum, exponent_product, exponent_difference, tentative_exponent,
                    input addend_shamt, sticky_before_add, final_sign, effective_sub,
                    input rnd_mode, result_is_special, special_result, special_status);
endinterface

/* src/fma_pipe_ctrl.sv */
`timescale 1ns/1ps

module fma_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  logic out_ready_i,
  output logic in_ready_o,
  output logic adv_o,       // Shared enable of both pipeline registers
  output logic out_valid_o
);

  logic stg1_valid_q; // Beat sitting in the stage-1 register

  // Global stall, whole pipe moves only if the output slot frees up
  assign adv_o      = ~out_valid_o | out_ready_i;
  assign in_ready_o = adv_o;

  always_ff @(posedge clk_i) begin : valid_regs
    if (!rst_n_i) begin
      stg1_valid_q <= 1'b0;
      out_valid_o  <= 1'b0;
    end else if (adv_o) begin
      stg1_valid_q <= in_valid_i; // in_ready_o is high here, so this is the transfer
      out_valid_o  <= stg1_valid_q;
    end
  end

  // Output beat is held until the sink takes it
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o);

  // An empty output slot never blocks the pipe
  a_adv_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !out_valid_o |=> out_valid_o == $past(stg1_valid_q));

endmodule

/* src/fma_operand_prep.sv */
`timescale 1ns/1ps

module fma_operand_prep import fpu_fmt_pkg::*; import fpu_op_pkg::*; (
  input  fp_t [2:0]      operands_i, // a, b, c
  input  operation_e     op_i,
  input  logic           op_mod_i,
  input  roundmode_e     rnd_mode_i,
  fma_operand_if.prep    ops
);

  logic any_inf;
  logic any_nan;
  logic any_snan;
  logic product_inf;

  function automatic fp_info_t classify(input fp_t op);
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    fp_info_t info;
    exp_ones           = &op.exponent;
    exp_zero           = ~|op.exponent;
    man_zero           = ~|op.mantissa;
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1]; // Quiet bit clear
    info.is_quiet      = info.is_nan && op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  // --------------------------------------------------------------------------
  // Operation table
  // --------------------------------------------------------------------------
  always_comb begin : op_select
    ops.a      = operands_i[0];
    ops.b      = operands_i[1];
    ops.c      = operands_i[2];
    ops.info_a = classify(operands_i[0]);
    ops.info_b = classify(operands_i[1]);
    ops.info_c = classify(operands_i[2]);
    ops.c.sign = operands_i[2].sign ^ op_mod_i; // op_mod always negates the addend
    unique case (op_i)
      FMADD:  ;
      FNMSUB: ops.a.sign = ~operands_i[0].sign;
      ADD: begin
        ops.a      = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0}; // +1.0
        ops.info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      MUL: begin
        ops.c      = '{sign: 1'b1, exponent: '0, mantissa: '0}; // -0 keeps product sign of zeros
        ops.info_c = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign ops.effective_sub  = ops.a.sign ^ ops.b.sign ^ ops.c.sign;
  assign ops.tentative_sign = ops.a.sign ^ ops.b.sign;
  assign ops.rnd_mode       = rnd_mode_i;

  assign product_inf = ops.info_a.is_inf | ops.info_b.is_inf;
  assign any_inf     = product_inf | ops.info_c.is_inf;
  assign any_nan     = ops.info_a.is_nan | ops.info_b.is_nan | ops.info_c.is_nan;
  assign any_snan    = ops.info_a.is_signalling | ops.info_b.is_signalling
                     | ops.info_c.is_signalling;

  // --------------------------------------------------------------------------
  // Bypass result, rules checked in priority order
  // --------------------------------------------------------------------------
  always_comb begin : special_cases
    ops.result_is_special = 1'b1;
    ops.special_result    = QNAN;
    ops.special_status    = '0;
    if ((ops.info_a.is_inf && ops.info_b.is_zero) || (ops.info_a.is_zero && ops.info_b.is_inf))
      ops.special_status.NV = 1'b1;                 // inf * 0, even with a quiet NaN addend
    else if (any_nan)
      ops.special_status.NV = any_snan;
    else if (product_inf && ops.info_c.is_inf && ops.effective_sub)
      ops.special_status.NV = 1'b1;                 // inf - inf
    else if (product_inf)
      ops.special_result = '{sign: ops.tentative_sign, exponent: '1, mantissa: '0};
    else if (any_inf)
      ops.special_result = '{sign: ops.c.sign, exponent: '1, mantissa: '0};
    else
      ops.result_is_special = 1'b0;                 // Regular datapath result
  end

endmodule

/* src/fma_align_add.sv */
`timescale 1ns/1ps

module fma_align_add import fpu_fmt_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          adv_i,
  fma_operand_if.align  ops,
  fma_stage_if.producer stg
);

  logic signed [EXP_WIDTH-1:0]        exponent_a;
  logic signed [EXP_WIDTH-1:0]        exponent_b;
  logic signed [EXP_WIDTH-1:0]        exponent_addend;
  logic signed [EXP_WIDTH-1:0]        exponent_product;
  logic signed [EXP_WIDTH-1:0]        exponent_difference;
  logic        [SHAMT_WIDTH-1:0]      addend_shamt;
  logic        [2*PRECISION_BITS-1:0] product;
  logic        [SUM_WIDTH-1:0]        product_shifted;
  logic        [SUM_WIDTH+PRECISION_BITS-1:0] addend_wide; // Aligned addend and sticky bits
  logic        [SUM_WIDTH-1:0]        addend_shifted;
  logic                               sticky_before_add;
  logic        [SUM_WIDTH:0]          sum_raw;            // Extra carry bit
  logic                               sum_carry;

  // --------------------------------------------------------------------------
  // Exponents, subnormals and zeros count as encoded exponent 1
  // --------------------------------------------------------------------------
  assign exponent_a = signed'({2'b00, ops.a.exponent[EXP_BITS-1:1],
                               ops.a.exponent[0] | ops.info_a.is_subnormal});
  assign exponent_b = signed'({2'b00, ops.b.exponent[EXP_BITS-1:1],
                               ops.b.exponent[0] | ops.info_b.is_subnormal});
  assign exponent_addend = signed'({2'b00, ops.c.exponent[EXP_BITS-1:1],
                                    ops.c.exponent[0] | ~ops.info_c.is_normal});
  assign exponent_product = (ops.info_a.is_zero || ops.info_b.is_zero)
                          ? EXP_WIDTH'(2 - BIAS)     // Zero product sits at minimum exponent
                          : exponent_a + exponent_b - EXP_WIDTH'(BIAS);
  assign exponent_difference = exponent_addend - exponent_product;

  always_comb begin : addend_shift_amount
    if (exponent_difference <= -2 * PRECISION_BITS - 1)
      addend_shamt = SHAMT_WIDTH'(SUM_WIDTH);  // Addend lands in sticky only
    else if (exponent_difference <= PRECISION_BITS + 2)
      addend_shamt = SHAMT_WIDTH'(PRECISION_BITS + 3 - exponent_difference);
    else
      addend_shamt = '0;                       // Addend-anchored, product goes to sticky
  end

  // Product padded with two low bits for round and sticky
  assign product         = {ops.info_a.is_normal, ops.a.mantissa}
                         * {ops.info_b.is_normal, ops.b.mantissa};
  assign product_shifted = SUM_WIDTH'(product) << 2;

  assign addend_wide       = {ops.info_c.is_normal, ops.c.mantissa, {SUM_WIDTH{1'b0}}}
                           >> addend_shamt;
  assign sticky_before_add = |addend_wide[PRECISION_BITS-1:0];
  assign addend_shifted    = ops.effective_sub
                           ? ~addend_wide[SUM_WIDTH+PRECISION_BITS-1:PRECISION_BITS]
                           : addend_wide[SUM_WIDTH+PRECISION_BITS-1:PRECISION_BITS];

  // Two's complement only completes when no sticky bits were lost
  assign sum_raw   = {1'b0, product_shifted} + {1'b0, addend_shifted}
                   + (SUM_WIDTH+1)'(ops.effective_sub & ~sticky_before_add);
  assign sum_carry = sum_raw[SUM_WIDTH];

  // --------------------------------------------------------------------------
  // Stage-1 register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin : stage1_ctrl
    if (!rst_n_i)   stg.result_is_special <= 1'b0;
    else if (adv_i) stg.result_is_special <= ops.result_is_special;
  end

  always_ff @(posedge clk_i) begin : stage1_data
    if (adv_i) begin
      // No carry on a subtraction means the sum went negative
      stg.sum                 <= (ops.effective_sub && !sum_carry) ? -sum_raw[SUM_WIDTH-1:0]
                                                                   : sum_raw[SUM_WIDTH-1:0];
      stg.final_sign          <= ops.effective_sub ? (sum_carry == ops.tentative_sign)
                                                   : ops.tentative_sign;
      stg.exponent_product    <= exponent_product;
      stg.exponent_difference <= exponent_difference;
      stg.tentative_exponent  <= (exponent_difference > 0) ? exponent_addend : exponent_product;
      stg.addend_shamt        <= addend_shamt;
      stg.sticky_before_add   <= sticky_before_add;
      stg.effective_sub       <= ops.effective_sub;
      stg.rnd_mode            <= ops.rnd_mode;
      stg.special_result      <= ops.special_result;
      stg.special_status      <= ops.special_status;
    end
  end

  a_shamt_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stg.addend_shamt <= SHAMT_WIDTH'(SUM_WIDTH));

endmodule

/* src/fma_normalize.sv */
`timescale 1ns/1ps

module fma_normalize import fpu_fmt_pkg::*; (
  fma_stage_if.consumer               stg,
  output logic [PRECISION_BITS:0]     final_mantissa_o, // Implicit bit, mantissa, round bit
  output logic signed [EXP_WIDTH-1:0] final_exponent_o,
  output logic                        sticky_o
);

  logic        [LZC_WIDTH-1:0]         lzc;
  logic                                lzc_zeroes;   // Lower sum is all zero
  logic signed [EXP_WIDTH-1:0]         exp_lzc;      // Product exponent after cancellation
  logic        [SHAMT_WIDTH-1:0]       norm_shamt;
  logic signed [EXP_WIDTH-1:0]         normalized_exponent;
  logic        [SUM_WIDTH:0]           sum_shifted;
  logic        [LOWER_SUM_WIDTH-1:0]   sum_sticky_bits;

  // Leading zeros of the lower 2p+3 sum bits
  always_comb begin : lead_zero_count
    lzc        = '0;
    lzc_zeroes = 1'b1;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (lzc_zeroes && stg.sum[LOWER_SUM_WIDTH-1-i]) begin
        lzc        = LZC_WIDTH'(i);
        lzc_zeroes = 1'b0;
      end
    end
  end

  assign exp_lzc = stg.exponent_product - signed'(EXP_WIDTH'(lzc)) + 7'sd1;

  // --------------------------------------------------------------------------
  // Large normalization shift
  // --------------------------------------------------------------------------
  always_comb begin : norm_shift_amount
    if ((stg.exponent_difference <= 0) || (stg.effective_sub && stg.exponent_difference <= 2)) begin
      if ((exp_lzc >= 0) && !lzc_zeroes) begin
        norm_shamt          = SHAMT_WIDTH'(PRECISION_BITS + 2 + lzc); // Drop counted zeros
        normalized_exponent = exp_lzc;
      end else begin
        // Subnormal result, stop at the minimum exponent
        norm_shamt          = SHAMT_WIDTH'(PRECISION_BITS + 2 + stg.exponent_product);
        normalized_exponent = '0;
      end
    end else begin
      norm_shamt          = stg.addend_shamt; // Addend-anchored, undo the alignment
      normalized_exponent = stg.tentative_exponent;
    end
  end

  assign sum_shifted = (SUM_WIDTH+1)'(stg.sum) << norm_shamt;

  // One-bit correction, leading one may sit one place off
  always_comb begin : small_norm
    {final_mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exponent_o                    = normalized_exponent;
    if (sum_shifted[SUM_WIDTH]) begin                 // Carry out, go right
      {final_mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exponent_o                    = normalized_exponent + 7'sd1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      // Already normalized
    end else if (normalized_exponent > 1) begin
      {final_mantissa_o, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exponent_o                    = normalized_exponent - 7'sd1;
    end else begin
      final_exponent_o = '0;                          // Stays subnormal
    end
  end

  assign sticky_o = (|sum_sticky_bits) | stg.sticky_before_add;

endmodule

/* src/fma_round.sv */
`timescale 1ns/1ps

module fma_round import fpu_fmt_pkg::*; import fpu_op_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        adv_i,
  input  logic [PRECISION_BITS:0]     final_mantissa_i,
  input  logic signed [EXP_WIDTH-1:0] final_exponent_i,
  input  logic                        sticky_i,
  fma_stage_if.consumer               stg,
  output fp_t                         result_o,
  output status_t                     status_o
);

  logic                         of_before_round;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs;
  logic [1:0]                   round_sticky; // {round, sticky}
  logic                         round_up;
  logic [EXP_BITS+MAN_BITS-1:0] rounded_abs;
  logic                         exact_zero;
  logic                         rounded_sign;
  logic                         of_after_round;
  logic                         uf_after_round;
  status_t                      regular_status;

  // Overflow saturates to max normal with RS set, rounding decides inf
  assign of_before_round = final_exponent_i >= 2 ** EXP_BITS - 1;
  assign pre_round_abs   = of_before_round
                         ? {EXP_BITS'(2 ** EXP_BITS - 2), {MAN_BITS{1'b1}}}
                         : {final_exponent_i[EXP_BITS-1:0], final_mantissa_i[MAN_BITS:1]};
  assign round_sticky    = {final_mantissa_i[0], sticky_i} | {2{of_before_round}};

  always_comb begin : round_decision
    unique case (stg.rnd_mode)
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & stg.final_sign;
      RUP:     round_up = (|round_sticky) & ~stg.final_sign;
      RMM:     round_up = round_sticky[1];
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs  = pre_round_abs + (EXP_BITS+MAN_BITS)'(round_up); // Carry bumps exponent
  assign exact_zero   = (pre_round_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && stg.effective_sub) ? (stg.rnd_mode == RDN)
                                                          : stg.final_sign;

  assign of_after_round = &rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];
  assign uf_after_round = ~|rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] & ~exact_zero;

  assign regular_status.NV = 1'b0;
  assign regular_status.DZ = 1'b0;
  assign regular_status.OF = of_before_round | of_after_round;
  assign regular_status.NX = (|round_sticky) | of_before_round | of_after_round;
  assign regular_status.UF = uf_after_round & regular_status.NX; // Tiny and inexact

  // --------------------------------------------------------------------------
  // Result select and output register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin : out_reg
    if (adv_i) begin
      result_o <= stg.result_is_special ? stg.special_result : {rounded_sign, rounded_abs};
      status_o <= stg.result_is_special ? stg.special_status : regular_status;
    end
  end

  a_no_nv_regular: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    adv_i && !stg.result_is_special |=> !status_o.NV);

endmodule

/* src/fpu_fma.sv */
`timescale 1ns/1ps

module fpu_fma import fpu_fmt_pkg::*; import fpu_op_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [2:0][FP_WIDTH-1:0] operands_i,
  input  operation_e               op_i,
  input  logic                     op_mod_i,
  input  roundmode_e               rnd_mode_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output logic [FP_WIDTH-1:0]      result_o,
  output status_t                  status_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  logic                        adv;
  logic [PRECISION_BITS:0]     final_mantissa;
  logic signed [EXP_WIDTH-1:0] final_exponent;
  logic                        sticky;

  fma_operand_if ops_if ();
  fma_stage_if   stg_if ();

  fma_pipe_ctrl i_pipe_ctrl (
    .clk_i, .rst_n_i, .in_valid_i, .out_ready_i, .in_ready_o, .adv_o (adv), .out_valid_o
  );

  // Stage 0 into the stage-1 register
  fma_operand_prep i_prep (.operands_i, .op_i, .op_mod_i, .rnd_mode_i, .ops (ops_if));
  fma_align_add i_align (.clk_i, .rst_n_i, .adv_i (adv), .ops (ops_if), .stg (stg_if));

  // Stage 1 into the output register
  fma_normalize i_norm (.stg (stg_if), .final_mantissa_o (final_mantissa),
                        .final_exponent_o (final_exponent), .sticky_o (sticky));
  fma_round i_round (.clk_i, .rst_n_i, .adv_i (adv), .final_mantissa_i (final_mantissa),
                     .final_exponent_i (final_exponent), .sticky_i (sticky), .stg (stg_if),
                     .result_o, .status_o);

endmodule

/* verification/tb_fma_model_pkg.sv */
package tb_fma_model_pkg;
  import fpu_op_pkg::*;

  localparam int          NUM_BEATS  = 4000;
  localparam int          CLK_PERIOD = 8;             // ns
  localparam logic [31:0] SEED       = 32'h293c_9a21;

  function automatic logic is_inf(input logic [15:0] x);
    return (&x[14:10]) && (x[9:0] == '0);
  endfunction

  function automatic logic is_nan(input logic [15:0] x);
    return (&x[14:10]) && (x[9:0] != '0);
  endfunction

  function automatic logic is_snan(input logic [15:0] x);
    return is_nan(x) && !x[9];                        // Quiet bit clear
  endfunction

  function automatic logic is_zero(input logic [15:0] x);
    return x[14:0] == '0;
  endfunction

  // Finite value is sig * 2^(exp - 25)
  function automatic logic [10:0] sig_of(input logic [15:0] x);
    return {|x[14:10], x[9:0]};
  endfunction

  function automatic int exp_of(input logic [15:0] x);
    return (x[14:10] == '0) ? 1 : int'(x[14:10]);
  endfunction

  // --------------------------------------------------------------------------
  // Exact a*b+c in units of 2^-50, then one rounding to binary16
  // --------------------------------------------------------------------------
  // flags is {NV, DZ, OF, UF, NX}
  function automatic void fma_ref(input logic [15:0] a_in, b_in, c_in,
                                  input operation_e op, input logic op_mod,
                                  input roundmode_e rnd,
                                  output logic [15:0] res, output logic [4:0] flags);
    logic [15:0]  a;
    logic [15:0]  b;
    logic [15:0]  c;
    logic [127:0] prod;
    logic [127:0] addend;
    logic [127:0] mag;
    logic [127:0] q;
    logic         sp;
    logic         sign;
    logic         eff_sub;
    logic         guard;
    logic         stk;
    logic         inexact;
    logic         up;
    int           n;
    int           sh;
    a = a_in;
    b = b_in;
    c = c_in ^ {op_mod, 15'd0};                       // op_mod negates the addend
    if (op == FNMSUB) a[15] = ~a[15];
    if (op == ADD) a = 16'h3C00;                      // +1.0
    if (op == MUL) c = 16'h8000;                      // -0
    sp      = a[15] ^ b[15];
    eff_sub = sp ^ c[15];
    flags   = '0;
    res     = 16'h7E00;
    if ((is_inf(a) && is_zero(b)) || (is_zero(a) && is_inf(b)))
      flags[4] = 1'b1;
    else if (is_nan(a) || is_nan(b) || is_nan(c))
      flags[4] = is_snan(a) || is_snan(b) || is_snan(c);
    else if ((is_inf(a) || is_inf(b)) && is_inf(c) && eff_sub)
      flags[4] = 1'b1;
    else if (is_inf(a) || is_inf(b))
      res = {sp, 15'h7C00};
    else if (is_inf(c))
      res = {c[15], 15'h7C00};
    else begin
      prod   = (128'(sig_of(a)) * 128'(sig_of(b))) << (exp_of(a) + exp_of(b));
      addend = 128'(sig_of(c)) << (exp_of(c) + 25);
      if (!eff_sub) begin
        mag  = prod + addend;
        sign = sp;
      end else if (prod >= addend) begin
        mag  = prod - addend;
        sign = sp;
      end else begin
        mag  = addend - prod;
        sign = c[15];
      end
      if (mag == '0) begin
        res = {eff_sub ? (rnd == RDN) : sp, 15'd0};  // Exact zero
      end else begin
        n = 127;
        while (!mag[n]) n--;
        sh      = (n - 10 > 26) ? n - 10 : 26;        // Subnormal quantum is 2^-24
        q       = mag >> sh;
        guard   = mag[sh-1];
        stk     = (mag & ((128'd1 << (sh - 1)) - 1)) != '0;
        inexact = guard | stk;
        case (rnd)
          RNE:     up = guard & (stk | q[0]);
          RTZ:     up = 1'b0;
          RDN:     up = inexact & sign;
          RUP:     up = inexact & ~sign;
          default: up = guard;                        // RMM
        endcase
        q = q + 128'(up) + (128'(sh - 26) << 10);     // Carry moves into the exponent
        if (q >= 128'h7C00) begin
          flags[2] = 1'b1;
          flags[0] = 1'b1;
          if (rnd == RTZ || (rnd == RDN && !sign) || (rnd == RUP && sign))
            res = {sign, 15'h7BFF};                   // Largest finite
          else
            res = {sign, 15'h7C00};
        end else begin
          res      = {sign, q[14:0]};
          flags[0] = inexact;
          flags[1] = inexact && (q < 128'h400);       // Tiny after rounding
        end
      end
    end
  endfunction

endpackage

/* verification/tb_fpu_fma.sv */
`timescale 1ns/1ps

module tb_fpu_fma import fpu_fmt_pkg::*; import fpu_op_pkg::*; import tb_fma_model_pkg::*; ();

  logic                     clk_i;
  logic                     rst_n_i;
  logic [2:0][FP_WIDTH-1:0] operands_i;
  operation_e               op_i;
  logic                     op_mod_i;
  roundmode_e               rnd_mode_i;
  logic                     in_valid_i;
  logic                     in_ready_o;
  logic [FP_WIDTH-1:0]      result_o;
  status_t                  status_o;
  logic                     out_valid_o;
  logic                     out_ready_i;

  logic [20:0] expected_q[$];   // {result, flags} in acceptance order
  int          errors;
  int          accepted;
  int          received;
  logic        in_fire;         // Input transfer at the coming edge
  logic        hold_pending;    // Output stalled at the coming edge
  logic [20:0] held_beat;

  fpu_fma i_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Mix of specials, subnormals, near-unity and wide-range normals
  function automatic logic [15:0] rand_operand();
    int          kind;
    logic [15:0] x;
    kind = $urandom_range(99);
    x    = 16'($urandom);
    if (kind < 15) begin
      case ($urandom_range(3))
        0:       x[14:0] = {5'h1F, 1'b0, x[8:0] | 9'h1}; // sNaN
        1:       x[14:0] = {5'h1F, 1'b1, x[8:0]};        // qNaN
        2:       x[14:0] = 15'h7C00;
        default: x[14:0] = '0;
      endcase
    end else if (kind < 30) begin
      x[14:10] = '0;                                      // Subnormal
    end else if (kind < 60) begin
      x[14:10] = 5'(12 + $urandom_range(6));              // Overlapping exponents
    end else if (x[14:10] == 5'h1F) begin
      x[14:10] = 5'h1E;
    end
    return x;
  endfunction

  task automatic check_output();
    logic [20:0] beat;
    assert (expected_q.size() != 0) else begin
      errors++;
      $display("Output transfer with no accepted beat outstanding");
    end
    if (expected_q.size() != 0) begin
      beat = expected_q.pop_front();
      assert (result_o == beat[20:5]) else begin
        errors++;
        $display("MISMATCH result_o: got %h, expected %h", result_o, beat[20:5]);
      end
      assert (5'(status_o) == beat[4:0]) else begin
        errors++;
        $display("MISMATCH status_o: got %h, expected %h", 5'(status_o), beat[4:0]);
      end
    end
    received++;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus, new beat only when the last one was taken
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : drive_inputs
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    if (rst_n_i) begin
      out_ready_i <= ($urandom_range(99) < 70);
      if (!in_valid_i || in_fire) begin
        a = rand_operand();
        b = rand_operand();
        c = rand_operand();
        if ($urandom_range(9) == 0) begin               // c close to -a*b
          b = {1'($urandom), 5'd15, 8'd0, 2'($urandom)};
          c = {~(a[15] ^ b[15]), a[14:0] ^ 15'($urandom_range(7))};
        end
        in_valid_i <= (accepted < NUM_BEATS) && ($urandom_range(99) < 80);
        operands_i <= {c, b, a};
        op_i       <= operation_e'($urandom_range(3));
        op_mod_i   <= 1'($urandom);
        rnd_mode_i <= roundmode_e'($urandom_range(4));
      end
    end
  end

  // Scoreboard, sampled mid-cycle where all signals are settled
  always @(negedge clk_i) begin : monitor
    logic [15:0] exp_res;
    logic [4:0]  exp_flags;
    in_fire = 1'b0;
    if (rst_n_i) begin
      in_fire = in_valid_i && in_ready_o;
      if (in_fire) begin
        fma_ref(operands_i[0], operands_i[1], operands_i[2], op_i, op_mod_i, rnd_mode_i,
                exp_res, exp_flags);
        expected_q.push_back({exp_res, exp_flags});
        accepted++;
      end
      if (hold_pending) begin
        assert (out_valid_o) else begin
          errors++;
          $display("out_valid_o dropped while the output was stalled");
        end
        assert ({result_o, 5'(status_o)} == held_beat) else begin
          errors++;
          $display("MISMATCH result_o and status_o under stall: got %h, expected %h",
                   {result_o, 5'(status_o)}, held_beat);
        end
      end
      if (out_valid_o && out_ready_i) check_output();
      hold_pending = out_valid_o && !out_ready_i;
      held_beat    = {result_o, 5'(status_o)};
    end
  end

  initial begin : main
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    operands_i   = '0;
    op_i         = FMADD;
    op_mod_i     = 1'b0;
    rnd_mode_i   = RNE;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b0;
    errors       = 0;
    accepted     = 0;
    received     = 0;
    in_fire      = 1'b0;
    hold_pending = 1'b0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && in_ready_o) else begin
      errors++;
      $display("After reset out_valid_o is not low or in_ready_o is not high");
    end
    wait (received == NUM_BEATS);
    assert (expected_q.size() == 0) else begin
      errors++;
      $display("Accepted beats never came out: %0d", expected_q.size());
    end
    $display("Beats checked: %0d, errors: %0d", received, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Generous bound, about 20 cycles per beat
  initial begin : watchdog
    #(NUM_BEATS * 20 * CLK_PERIOD);
    $display("Timeout after %0d of %0d beats, errors: %0d", received, NUM_BEATS, errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* fpu_fma.f */
src/fpu_fmt_pkg.sv
src/fpu_op_pkg.sv
src/fma_ifs.sv
src/fma_pipe_ctrl.sv
src/fma_operand_prep.sv
src/fma_align_add.sv
src/fma_normalize.sv
src/fma_round.sv
src/fpu_fma.sv
verification/tb_fma_model_pkg.sv
verification/tb_fpu_fma.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fpu_fma
FLIST     ?= fpu_fma.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
